/* hdl/fpFormatPkg.sv */
package fpFormatPkg;

    // Single-precision word: sign, 8-bit exponent, 23-bit fraction
    typedef logic [31:0] fp32Word;

    // Exception flags, NV in the top bit down to NX
    typedef logic [4:0] fpFlags;

    // Classify result, one-hot in RISC-V bit order
    typedef logic [9:0] fpClassMask;

    localparam int EXP_WIDTH = 8;
    localparam int FRAC_WIDTH = 23;

    // Quiet NaN with an all-zero payload below the quiet bit
    localparam fp32Word CANONICAL_NAN = 32'h7fc0_0000;

    // Invalid-operation bit position inside fpFlags
    localparam int FLAG_NV = 4;

    // Bit positions of the classify mask
    localparam int CLASS_NEG_INF = 0;
    localparam int CLASS_NEG_NORMAL = 1;
    localparam int CLASS_NEG_SUBNORMAL = 2;
    localparam int CLASS_NEG_ZERO = 3;
    localparam int CLASS_POS_ZERO = 4;
    localparam int CLASS_POS_SUBNORMAL = 5;
    localparam int CLASS_POS_NORMAL = 6;
    localparam int CLASS_POS_INF = 7;
    localparam int CLASS_SIGNALING_NAN = 8;
    localparam int CLASS_QUIET_NAN = 9;

endpackage

/* hdl/fpPipePkg.sv */
package fpPipePkg;

    // Operations this lane can execute
    typedef enum logic [3:0] {
        FSGNJ,
        FSGNJN,
        FSGNJX,
        FCLASS,
        FMIN,
        FMAX,
        FEQ,
        FLT,
        FLE
    } fpOpCode;

    // Active list holds 32 entries
    localparam int ACTIVE_LIST_INDEX_WIDTH = 5;

    typedef logic [ACTIVE_LIST_INDEX_WIDTH-1:0] activeListIndex;

endpackage

/* hdl/flushRangeDetector.sv */
`timescale 1ns/1ps

module flushRangeDetector
    import fpPipePkg::*;
(
    input  logic           recoveryPhase,
    input  logic           flushAll,
    input  activeListIndex flushHead,
    input  activeListIndex flushTail,
    input  activeListIndex index,
    output logic           flushed
);

    logic inRange;

    always_comb begin
        if (flushHead <= flushTail) begin
            // Plain window, empty when head equals tail
            inRange = (index >= flushHead) && (index < flushTail);
        end else begin
            // Window wraps past the last active-list entry
            inRange = (index >= flushHead) || (index < flushTail);
        end
    end

    assign flushed = recoveryPhase && (flushAll || inRange);

endmodule

/* hdl/fpOpTracker.sv */
`timescale 1ns/1ps

module fpOpTracker
    import fpFormatPkg::*;
    import fpPipePkg::*;
#(
    parameter int EXEC_DEPTH = 3
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall,
    input  logic           clear,
    input  logic           issueValid,
    input  logic           operandValidA,
    input  logic           operandValidB,
    input  fpOpCode        issueOp,
    input  activeListIndex issueTag,
    input  fp32Word        operandA,
    input  fp32Word        operandB,
    input  logic           recoveryPhase,
    input  logic           flushAll,
    input  activeListIndex flushHead,
    input  activeListIndex flushTail,
    output fpOpCode        stageOp,
    output fp32Word        stageOperandA,
    output fp32Word        stageOperandB,
    output logic           outValid,
    output activeListIndex outTag,
    output logic           replayValid,
    output activeListIndex replayTag
);

    // Input register (stage 0)
    logic stageValid;
    logic stageReady;
    activeListIndex stageTag;

    // Local stages 1 .. EXEC_DEPTH-1
    logic [EXEC_DEPTH-2:0] localValid;
    logic [EXEC_DEPTH-2:0] localReady;
    activeListIndex localTag [EXEC_DEPTH-1];

    activeListIndex trackedTag [EXEC_DEPTH];
    logic [EXEC_DEPTH-1:0] flush;
    logic issueReady;

    // FCLASS reads only the first source
    assign issueReady = (issueOp == FCLASS) ? operandValidA
                                            : (operandValidA && operandValidB);

    always_ff @(posedge clk) begin
        if (reset || clear) begin
            stageValid <= 1'b0;
            stageReady <= 1'b0;
            localValid <= '0;
            localReady <= '0;
        end else if (!stall) begin
            stageValid <= issueValid;
            stageReady <= issueReady;
            localValid[0] <= stageValid && !flush[0];
            localReady[0] <= stageReady;
            for (int j = 1; j < EXEC_DEPTH-1; j++) begin
                localValid[j] <= localValid[j-1] && !flush[j];
                localReady[j] <= localReady[j-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            stageOp <= issueOp;
            stageTag <= issueTag;
            stageOperandA <= operandA;
            stageOperandB <= operandB;
            localTag[0] <= stageTag;
            for (int j = 1; j < EXEC_DEPTH-1; j++) begin
                localTag[j] <= localTag[j-1];
            end
        end
    end

    assign trackedTag[0] = stageTag;

    for (genvar j = 1; j < EXEC_DEPTH; j++) begin : gLocalTag
        assign trackedTag[j] = localTag[j-1];
    end

    // One range check per stage
    for (genvar j = 0; j < EXEC_DEPTH; j++) begin : gFlush
        flushRangeDetector flushDetect (
            .recoveryPhase(recoveryPhase),
            .flushAll     (flushAll),
            .flushHead    (flushHead),
            .flushTail    (flushTail),
            .index        (trackedTag[j]),
            .flushed      (flush[j])
        );
    end

    // Operand not ready at capture, ask the scheduler to reissue
    assign replayValid = localValid[0] && !localReady[0] && !stall && !clear && !flush[1];
    assign replayTag = localTag[0];

    assign outValid = localValid[EXEC_DEPTH-2] && localReady[EXEC_DEPTH-2]
                      && !stall && !clear && !flush[EXEC_DEPTH-1];
    assign outTag = localTag[EXEC_DEPTH-2];

    replayExcludesOutput: assert property (
        @(posedge clk) disable iff (reset) !(replayValid && outValid && replayTag == outTag)
    ) else $error("same tag both replayed and completed");

endmodule

/* hdl/fpMoveUnit.sv */
`timescale 1ns/1ps

module fpMoveUnit
    import fpFormatPkg::*;
    import fpPipePkg::*;
(
    input  fpOpCode op,
    input  fp32Word operandA,
    input  fp32Word operandB,
    output fp32Word result
);

    logic signA;
    logic [EXP_WIDTH-1:0] expA;
    logic [FRAC_WIDTH-1:0] fracA;
    logic expAllOnes;
    logic expZero;
    logic fracZero;
    fpClassMask classMask;

    assign {signA, expA, fracA} = operandA;
    assign expAllOnes = &expA;
    assign expZero = (expA == '0);
    assign fracZero = (fracA == '0);

    always_comb begin
        classMask[CLASS_NEG_INF] = signA && expAllOnes && fracZero;
        classMask[CLASS_NEG_NORMAL] = signA && !expAllOnes && !expZero;
        classMask[CLASS_NEG_SUBNORMAL] = signA && expZero && !fracZero;
        classMask[CLASS_NEG_ZERO] = signA && expZero && fracZero;
        classMask[CLASS_POS_ZERO] = !signA && expZero && fracZero;
        classMask[CLASS_POS_SUBNORMAL] = !signA && expZero && !fracZero;
        classMask[CLASS_POS_NORMAL] = !signA && !expAllOnes && !expZero;
        classMask[CLASS_POS_INF] = !signA && expAllOnes && fracZero;
        // Quiet bit is the fraction MSB
        classMask[CLASS_SIGNALING_NAN] = expAllOnes && !fracZero && !fracA[FRAC_WIDTH-1];
        classMask[CLASS_QUIET_NAN] = expAllOnes && fracA[FRAC_WIDTH-1];
    end

    always_comb begin
        case (op)
            FSGNJ:   result = {operandB[31], operandA[30:0]};
            FSGNJN:  result = {~operandB[31], operandA[30:0]};
            FSGNJX:  result = {operandA[31] ^ operandB[31], operandA[30:0]};
            FCLASS:  result = fp32Word'(classMask);
            default: result = '0;
        endcase
    end

endmodule

/* hdl/fpCompareUnit.sv */
`timescale 1ns/1ps

module fpCompareUnit
    import fpFormatPkg::*;
    import fpPipePkg::*;
(
    input  fpOpCode op,
    input  fp32Word operandA,
    input  fp32Word operandB,
    output fp32Word result,
    output fpFlags  flags
);

    logic nanA;
    logic nanB;
    logic anyNaN;
    logic anySignaling;
    logic bothZero;
    logic signedLess;
    logic lessThan;
    logic equal;

    function automatic logic isNaN(fp32Word value);
        return (&value[FRAC_WIDTH +: EXP_WIDTH]) && (value[FRAC_WIDTH-1:0] != '0);
    endfunction

    assign nanA = isNaN(operandA);
    assign nanB = isNaN(operandB);
    assign anyNaN = nanA || nanB;
    assign anySignaling = (nanA && !operandA[FRAC_WIDTH-1]) || (nanB && !operandB[FRAC_WIDTH-1]);
    assign bothZero = (operandA[30:0] == '0) && (operandB[30:0] == '0);

    // Sign-magnitude order, -0 sits below +0 here
    always_comb begin
        if (operandA[31] != operandB[31]) begin
            signedLess = operandA[31];
        end else if (operandA[31]) begin
            signedLess = operandA[30:0] > operandB[30:0];
        end else begin
            signedLess = operandA[30:0] < operandB[30:0];
        end
    end

    // IEEE ordering treats the two zeros as equal
    assign lessThan = signedLess && !bothZero;
    assign equal = (operandA == operandB) || bothZero;

    always_comb begin
        result = '0;
        flags = '0;
        case (op)
            FEQ: begin
                result = fp32Word'(equal && !anyNaN);
                flags[FLAG_NV] = anySignaling;
            end
            FLT: begin
                result = fp32Word'(lessThan && !anyNaN);
                flags[FLAG_NV] = anyNaN;
            end
            FLE: begin
                result = fp32Word'((lessThan || equal) && !anyNaN);
                flags[FLAG_NV] = anyNaN;
            end
            FMIN, FMAX: begin
                if (nanA && nanB)
                    result = CANONICAL_NAN;
                else if (nanA)
                    result = operandB;
                else if (nanB)
                    result = operandA;
                // A wins for min when smaller, for max when not smaller
                else if ((op == FMIN) == signedLess)
                    result = operandA;
                else
                    result = operandB;
                flags[FLAG_NV] = anySignaling;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

/* hdl/fpResultPipe.sv */
`timescale 1ns/1ps

module fpResultPipe
    import fpFormatPkg::*;
    import fpPipePkg::*;
#(
    parameter int EXEC_DEPTH = 3
) (
    input  logic    clk,
    input  logic    reset,
    input  logic    stall,
    input  fpOpCode op,
    input  fp32Word moveResult,
    input  fp32Word compareResult,
    input  fpFlags  compareFlags,
    output fp32Word outData,
    output fpFlags  outFlags
);

    fp32Word selData;
    fpFlags selFlags;
    fp32Word dataPipe [EXEC_DEPTH-1];
    fpFlags flagPipe [EXEC_DEPTH-1];

    // Sign injection and classify never raise flags
    always_comb begin
        if (op inside {FSGNJ, FSGNJN, FSGNJX, FCLASS}) begin
            selData = moveResult;
            selFlags = '0;
        end else begin
            selData = compareResult;
            selFlags = compareFlags;
        end
    end

    // Advances in step with the tracker's stage registers
    always_ff @(posedge clk) begin
        if (!stall) begin
            dataPipe[0] <= selData;
            flagPipe[0] <= selFlags;
            for (int j = 1; j < EXEC_DEPTH-1; j++) begin
                dataPipe[j] <= dataPipe[j-1];
                flagPipe[j] <= flagPipe[j-1];
            end
        end
    end

    assign outData = dataPipe[EXEC_DEPTH-2];
    assign outFlags = flagPipe[EXEC_DEPTH-2];

    knownOpcode: assert property (
        @(posedge clk) disable iff (reset) !stall |-> !$isunknown(op)
    ) else $error("unknown opcode entering result pipe");

endmodule

/* hdl/fpExecutionStage.sv */
`timescale 1ns/1ps

module fpExecutionStage
    import fpFormatPkg::*;
    import fpPipePkg::*;
#(
    parameter int EXEC_DEPTH = 3
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           stall,
    input  logic           clear,
    input  logic           issueValid,
    input  fpOpCode        issueOp,
    input  activeListIndex issueTag,
    input  fp32Word        operandA,
    input  fp32Word        operandB,
    input  logic           operandValidA,
    input  logic           operandValidB,
    input  logic           recoveryPhase,
    input  activeListIndex flushHead,
    input  activeListIndex flushTail,
    input  logic           flushAll,
    output logic           outValid,
    output activeListIndex outTag,
    output fp32Word        outData,
    output fpFlags         outFlags,
    output logic           replayValid,
    output activeListIndex replayTag
);

    fpOpCode stageOp;
    fp32Word stageOperandA;
    fp32Word stageOperandB;
    fp32Word moveResult;
    fp32Word compareResult;
    fpFlags compareFlags;

    fpOpTracker #(
        .EXEC_DEPTH(EXEC_DEPTH)
    ) tracker (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .clear        (clear),
        .issueValid   (issueValid),
        .operandValidA(operandValidA),
        .operandValidB(operandValidB),
        .issueOp      (issueOp),
        .issueTag     (issueTag),
        .operandA     (operandA),
        .operandB     (operandB),
        .recoveryPhase(recoveryPhase),
        .flushAll     (flushAll),
        .flushHead    (flushHead),
        .flushTail    (flushTail),
        .stageOp      (stageOp),
        .stageOperandA(stageOperandA),
        .stageOperandB(stageOperandB),
        .outValid     (outValid),
        .outTag       (outTag),
        .replayValid  (replayValid),
        .replayTag    (replayTag)
    );

    // Both units see the stage 0 operands
    fpMoveUnit moveUnit (
        .op      (stageOp),
        .operandA(stageOperandA),
        .operandB(stageOperandB),
        .result  (moveResult)
    );

    fpCompareUnit compareUnit (
        .op      (stageOp),
        .operandA(stageOperandA),
        .operandB(stageOperandB),
        .result  (compareResult),
        .flags   (compareFlags)
    );

    fpResultPipe #(
        .EXEC_DEPTH(EXEC_DEPTH)
    ) resultPipe (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .op           (stageOp),
        .moveResult   (moveResult),
        .compareResult(compareResult),
        .compareFlags (compareFlags),
        .outData      (outData),
        .outFlags     (outFlags)
    );

endmodule

/* test/fpExecStageTb.sv */
`timescale 1ns/1ps

module fpExecStageTb
    import fpFormatPkg::*;
    import fpPipePkg::*;
();

    localparam int EXEC_DEPTH = 3;
    // All six tests together need roughly 600 cycles
    localparam int MAX_CYCLES = 2000;
    // Burst slot in which recovery rises, earlier ops are still in flight
    localparam int FLUSH_START = 3;

    logic clk;
    logic reset;
    logic stall;
    logic clear;
    logic issueValid;
    fpOpCode issueOp;
    activeListIndex issueTag;
    fp32Word operandA;
    fp32Word operandB;
    logic operandValidA;
    logic operandValidB;
    logic recoveryPhase;
    activeListIndex flushHead;
    activeListIndex flushTail;
    logic flushAll;
    logic outValid;
    activeListIndex outTag;
    fp32Word outData;
    fpFlags outFlags;
    logic replayValid;
    activeListIndex replayTag;

    integer seed = 32'h2adbd620;
    int cycle = 0;
    logic timedChecks;

    // Expected results in issue order
    activeListIndex expTag [$];
    fp32Word expData [$];
    fpFlags expFlags [$];
    int expCycle [$];
    // Expected replay requests
    activeListIndex repTag [$];
    int repCycle [$];

    fp32Word vectors [10] = '{
        32'h0000_0000,  // +0
        32'h8000_0000,  // -0
        32'h0000_0001,  // smallest positive subnormal
        32'h807f_ffff,  // largest negative subnormal
        32'h7f80_0000,  // +inf
        32'hff80_0000,  // -inf
        32'h7fc0_0000,  // quiet NaN
        32'h7f80_0001,  // signaling NaN
        32'h3f80_0000,  // 1.0
        32'hc049_0fdb   // -pi
    };

    fpExecutionStage #(
        .EXEC_DEPTH(EXEC_DEPTH)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .stall        (stall),
        .clear        (clear),
        .issueValid   (issueValid),
        .issueOp      (issueOp),
        .issueTag     (issueTag),
        .operandA     (operandA),
        .operandB     (operandB),
        .operandValidA(operandValidA),
        .operandValidB(operandValidB),
        .recoveryPhase(recoveryPhase),
        .flushHead    (flushHead),
        .flushTail    (flushTail),
        .flushAll     (flushAll),
        .outValid     (outValid),
        .outTag       (outTag),
        .outData      (outData),
        .outFlags     (outFlags),
        .replayValid  (replayValid),
        .replayTag    (replayTag)
    );

    initial clk = 1'b0;
    always #5 clk = ~clk;

    task automatic abortRun();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic reportProblem(input string msg);
        $display("Error at %0t: %s", $time, msg);
        abortRun();
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            abortRun();
        end
    end

    // Reference model
    function automatic logic isNan(input fp32Word v);
        return (v[30:23] == 8'hff) && (v[22:0] != 0);
    endfunction

    function automatic logic isSignalingNan(input fp32Word v);
        return isNan(v) && !v[22];
    endfunction

    // Signed magnitude as a plain integer, both zeros map to 0
    function automatic longint orderKey(input fp32Word v);
        return v[31] ? -longint'(v[30:0]) : longint'(v[30:0]);
    endfunction

    function automatic fpClassMask classMaskOf(input fp32Word v);
        fpClassMask m;
        m = '0;
        if (v[30:23] == 8'hff) begin
            if (v[22:0] == 0)
                m[v[31] ? 0 : 7] = 1'b1;
            else
                m[v[22] ? 9 : 8] = 1'b1;
        end else if (v[30:23] == 8'h00) begin
            if (v[22:0] == 0)
                m[v[31] ? 3 : 4] = 1'b1;
            else
                m[v[31] ? 2 : 5] = 1'b1;
        end else begin
            m[v[31] ? 1 : 6] = 1'b1;
        end
        return m;
    endfunction

    function automatic fp32Word modelData(input fpOpCode op, input fp32Word a, input fp32Word b);
        longint keyA;
        longint keyB;
        logic anyNan;
        keyA = orderKey(a);
        keyB = orderKey(b);
        anyNan = isNan(a) || isNan(b);
        case (op)
            FSGNJ:  return (a & 32'h7fff_ffff) | (b & 32'h8000_0000);
            FSGNJN: return (a & 32'h7fff_ffff) | (~b & 32'h8000_0000);
            FSGNJX: return a ^ (b & 32'h8000_0000);
            FCLASS: return fp32Word'(classMaskOf(a));
            FEQ:    return fp32Word'(!anyNan && (keyA == keyB));
            FLT:    return fp32Word'(!anyNan && (keyA < keyB));
            FLE:    return fp32Word'(!anyNan && (keyA <= keyB));
            FMIN, FMAX: begin
                if (isNan(a) && isNan(b))
                    return CANONICAL_NAN;
                if (isNan(a))
                    return b;
                if (isNan(b))
                    return a;
                // Equal keys with different words only for the two zeros
                if (keyA == keyB)
                    return ((op == FMIN) == a[31]) ? a : b;
                return ((keyA < keyB) == (op == FMIN)) ? a : b;
            end
            default: return '0;
        endcase
    endfunction

    function automatic fpFlags modelFlags(input fpOpCode op, input fp32Word a, input fp32Word b);
        logic invalid;
        case (op)
            FEQ, FMIN, FMAX: invalid = isSignalingNan(a) || isSignalingNan(b);
            FLT, FLE:        invalid = isNan(a) || isNan(b);
            default:         invalid = 1'b0;
        endcase
        return {invalid, 4'b0000};
    endfunction

    // Offset from head must fall below the range length
    function automatic logic inFlushRange(input activeListIndex tag, input activeListIndex head,
                                          input activeListIndex tail);
        activeListIndex offset;
        activeListIndex span;
        offset = tag - head;
        span = tail - head;
        return offset < span;
    endfunction

    function automatic fp32Word randomOperand();
        fp32Word v;
        v = $random(seed);
        // Bias towards infinities, NaNs, zeros and subnormals
        case ($unsigned($random(seed)) % 4)
            0: v[30:23] = 8'hff;
            1: v[30:23] = 8'h00;
            default: ;
        endcase
        return v;
    endfunction

    function automatic fpOpCode randomOpcode();
        return fpOpCode'($unsigned($random(seed)) % 9);
    endfunction

    task automatic checkData(input fp32Word got, input fp32Word want, input string what);
        if (got !== want) begin
            $display("[FAIL] %0t: %s expected %h, got %h", $time, what, want, got);
            abortRun();
        end
    endtask

    task automatic checkFlags(input fpFlags got, input fpFlags want, input string what);
        if (got !== want) begin
            $display("[FAIL] %0t: %s expected %b, got %b", $time, what, want, got);
            abortRun();
        end
    endtask

    task automatic checkTag(input activeListIndex got, input activeListIndex want,
                            input string what);
        if (got !== want) begin
            $display("[FAIL] %0t: %s expected %0d, got %0d", $time, what, want, got);
            abortRun();
        end
    endtask

    task automatic checkLatency(input int want, input string what);
        if (want >= 0 && cycle != want) begin
            $display("[FAIL] %0t: %s in cycle %0d, expected cycle %0d", $time, what, cycle, want);
            abortRun();
        end
    endtask

    // Sampled mid-cycle where all DUT outputs are settled
    always @(negedge clk) begin : scoreboard
        activeListIndex wantTag;
        fp32Word wantData;
        fpFlags wantFlags;
        int wantCycle;
        if (!reset) begin
            if (stall && (outValid || replayValid)) begin
                reportProblem("a result or replay request left the lane while stalled");
            end
            if (replayValid) begin
                if (repTag.size() == 0) begin
                    reportProblem($sformatf("unexpected replay request for tag %0d", replayTag));
                end else begin
                    wantTag = repTag.pop_front();
                    wantCycle = repCycle.pop_front();
                    checkTag(replayTag, wantTag, "replay tag");
                    checkLatency(wantCycle, "replay request");
                end
            end
            if (outValid) begin
                if (expTag.size() == 0) begin
                    reportProblem($sformatf("unexpected result for tag %0d", outTag));
                end else begin
                    wantTag = expTag.pop_front();
                    wantData = expData.pop_front();
                    wantFlags = expFlags.pop_front();
                    wantCycle = expCycle.pop_front();
                    checkTag(outTag, wantTag, "result tag");
                    checkData(outData, wantData, $sformatf("data of tag %0d", wantTag));
                    checkFlags(outFlags, wantFlags, $sformatf("flags of tag %0d", wantTag));
                    checkLatency(wantCycle, "result");
                end
            end
        end
    end

    // Drives one issue slot and records what should come back
    task automatic driveOp(input fpOpCode op, input fp32Word a, input fp32Word b,
                           input activeListIndex tag, input logic validA, input logic validB,
                           input logic keep);
        logic ready;
        ready = (op == FCLASS) ? validA : (validA && validB);
        issueValid = 1'b1;
        issueOp = op;
        issueTag = tag;
        operandA = a;
        operandB = b;
        operandValidA = validA;
        operandValidB = validB;
        if (keep && ready) begin
            expTag.push_back(tag);
            expData.push_back(modelData(op, a, b));
            expFlags.push_back(modelFlags(op, a, b));
            expCycle.push_back(timedChecks ? cycle + EXEC_DEPTH : -1);
        end else if (keep) begin
            repTag.push_back(tag);
            repCycle.push_back(timedChecks ? cycle + 2 : -1);
        end
    endtask

    task automatic issue(input fpOpCode op, input fp32Word a, input fp32Word b,
                         input activeListIndex tag, input logic validA, input logic validB,
                         input logic keep);
        @(posedge clk);
        #1;
        driveOp(op, a, b, tag, validA, validB, keep);
    endtask

    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
            issueValid = 1'b0;
        end
    endtask

    task automatic drain();
        idle(1);
        stall = 1'b0;
        while (expTag.size() != 0 || repTag.size() != 0) begin
            @(posedge clk);
        end
        idle(EXEC_DEPTH + 2);
    endtask

    task automatic moveTest();
        activeListIndex tag;
        tag = '0;
        for (int i = 0; i < 10; i++) begin
            // FSGNJ through FCLASS
            for (int k = 0; k < 4; k++) begin
                issue(fpOpCode'(k), vectors[i], vectors[(i + 3) % 10], tag, 1'b1, 1'b1, 1'b1);
                tag++;
            end
        end
        drain();
    endtask

    task automatic compareTest();
        int offsets [4] = '{0, 1, 3, 9};
        activeListIndex tag;
        tag = '0;
        for (int i = 0; i < 10; i++) begin
            for (int k = 0; k < 4; k++) begin
                for (int n = 0; n < 5; n++) begin
                    issue(fpOpCode'(int'(FMIN) + n), vectors[i], vectors[(i + offsets[k]) % 10],
                          tag, 1'b1, 1'b1, 1'b1);
                    tag++;
                end
            end
        end
        drain();
    endtask

    task automatic stallStreamTest();
        int issued;
        int stallLeft;
        activeListIndex tag;
        issued = 0;
        stallLeft = 0;
        tag = '0;
        timedChecks = 1'b0;
        while (issued < 40) begin
            @(posedge clk);
            #1;
            if (stallLeft == 0 && ($random(seed) & 3) == 0) begin
                stallLeft = 1 + ($unsigned($random(seed)) % 4);
            end
            if (stallLeft > 0) begin
                stall = 1'b1;
                issueValid = 1'b0;
                stallLeft--;
            end else begin
                stall = 1'b0;
                driveOp(randomOpcode(), randomOperand(), randomOperand(), tag, 1'b1, 1'b1, 1'b1);
                tag++;
                issued++;
            end
        end
        drain();
        timedChecks = 1'b1;
    endtask

    // Recovery rises mid-burst and stays up until the whole burst has left the lane
    task automatic flushBurst(input activeListIndex head, input activeListIndex tail,
                              input logic all, input activeListIndex firstTag);
        activeListIndex tag;
        logic hit;
        tag = firstTag;
        @(posedge clk);
        #1;
        flushHead = head;
        flushTail = tail;
        flushAll = all;
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            #1;
            if (i == FLUSH_START) begin
                recoveryPhase = 1'b1;
            end
            // An op that left the lane before recovery rose still completes
            hit = (all || inFlushRange(tag, head, tail)) && (i + EXEC_DEPTH >= FLUSH_START);
            driveOp(randomOpcode(), randomOperand(), randomOperand(), tag, 1'b1, 1'b1, !hit);
            tag++;
        end
        idle(EXEC_DEPTH + 1);
        recoveryPhase = 1'b0;
        flushAll = 1'b0;
        drain();
    endtask

    task automatic flushTest();
        flushBurst(5'd0, 5'd3, 1'b0, 5'd0);
        flushBurst(5'd30, 5'd2, 1'b0, 5'd29);
        flushBurst(5'd10, 5'd10, 1'b0, 5'd8);
        flushBurst(5'd0, 5'd0, 1'b1, 5'd16);
    endtask

    task automatic replayTest();
        issue(FMIN, vectors[8], vectors[9], 5'd8, 1'b1, 1'b1, 1'b1);
        // Second source missing
        issue(FEQ, vectors[8], vectors[8], 5'd9, 1'b1, 1'b0, 1'b1);
        issue(FLT, vectors[2], vectors[3], 5'd10, 1'b1, 1'b1, 1'b1);
        // Classify ignores the second source
        issue(FCLASS, vectors[7], vectors[0], 5'd11, 1'b1, 1'b0, 1'b1);
        issue(FCLASS, vectors[6], vectors[0], 5'd12, 1'b0, 1'b1, 1'b1);
        issue(FSGNJX, vectors[5], vectors[9], 5'd13, 1'b0, 1'b0, 1'b1);
        issue(FMAX, vectors[0], vectors[1], 5'd14, 1'b1, 1'b1, 1'b1);
        drain();
    endtask

    task automatic clearTest();
        for (int i = 0; i < EXEC_DEPTH; i++) begin
            issue(randomOpcode(), randomOperand(), randomOperand(), activeListIndex'(20 + i),
                  1'b1, 1'b1, 1'b0);
        end
        @(posedge clk);
        #1;
        issueValid = 1'b0;
        clear = 1'b1;
        @(posedge clk);
        #1;
        clear = 1'b0;
        for (int i = 0; i < 4; i++) begin
            issue(randomOpcode(), randomOperand(), randomOperand(), activeListIndex'(24 + i),
                  1'b1, 1'b1, 1'b1);
        end
        drain();
    endtask

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        clear = 1'b0;
        issueValid = 1'b0;
        issueOp = FSGNJ;
        issueTag = '0;
        operandA = '0;
        operandB = '0;
        operandValidA = 1'b0;
        operandValidB = 1'b0;
        recoveryPhase = 1'b0;
        flushHead = '0;
        flushTail = '0;
        flushAll = 1'b0;
        timedChecks = 1'b1;
        repeat (2) @(posedge clk);
        #1;
        reset = 1'b0;

        moveTest();
        compareTest();
        stallStreamTest();
        flushTest();
        replayTest();
        clearTest();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

/* list.f */
hdl/fpFormatPkg.sv
hdl/fpPipePkg.sv
hdl/flushRangeDetector.sv
hdl/fpOpTracker.sv
hdl/fpMoveUnit.sv
hdl/fpCompareUnit.sv
hdl/fpResultPipe.sv
hdl/fpExecutionStage.sv
test/fpExecStageTb.sv

/* Bender.yml */
package:
  name: fp_exec_stage

sources:
  - files:
      - hdl/fpFormatPkg.sv
      - hdl/fpPipePkg.sv
      - hdl/flushRangeDetector.sv
      - hdl/fpOpTracker.sv
      - hdl/fpMoveUnit.sv
      - hdl/fpCompareUnit.sv
      - hdl/fpResultPipe.sv
      - hdl/fpExecutionStage.sv
  - target: test
    files:
      - test/fpExecStageTb.sv
